// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := spdif_rx_tb
FILELIST   := spdif_rx.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing --top-module $(TOP)
SIM_FLAGS  := --binary --timing --assert -Wno-fatal --top-module $(TOP) -Mdir $(OBJ_DIR)
RUN_ARGS   := +verilator+error+limit+1000
PASS_MSG   := TESTBENCH PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

# The pipeline status is that of grep, so a missing pass line fails the target
sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) | tee /dev/stderr | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== design/spdif_bmc_decoder.sv ====
`timescale 1ns/1ps
`include "spdif_rx_defines.svh"

module spdif_bmc_decoder (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       signal_i,
    input  spdif_rx_pkg::halfbit_len_t halfbit_len_i,
    output spdif_rx_pkg::pulse_t       pulse_o
);

    logic [1:0]                sync_q;   // Line synchronizer
    logic                      line_q;   // Edge register
    logic                      edge_det;
    spdif_rx_pkg::pulse_len_t  cnt_q;    // Clocks spent at the current level
    logic                      stall_q;  // Stall already reported for this level
    logic                      stall_hit;
    logic [8:0]                hb9;
    logic [8:0]                lim_3;
    logic [8:0]                lim_5;
    logic [8:0]                lim_7;
    logic [8:0]                cnt2;
    spdif_rx_pkg::pulse_kind_e kind;

    // Compare in doubled units, so 1.5, 2.5 and 3.5 half-bits stay integral
    assign hb9   = {{(9 - `SPDIF_HB_W){1'b0}}, halfbit_len_i};
    assign lim_3 = (hb9 << 1) + hb9;
    assign lim_5 = (hb9 << 2) + hb9;
    assign lim_7 = (hb9 << 3) - hb9;
    assign cnt2  = {cnt_q, 1'b0};

    assign edge_det  = sync_q[1] ^ line_q;
    assign stall_hit = !edge_det && !stall_q && (cnt2 >= lim_7);

    always_comb begin
        if (cnt2 < lim_3)
            kind = spdif_rx_pkg::PULSE_ONE;
        else if (cnt2 < lim_5)
            kind = spdif_rx_pkg::PULSE_TWO;
        else if (cnt2 < lim_7)
            kind = spdif_rx_pkg::PULSE_THREE;
        else
            kind = spdif_rx_pkg::PULSE_BAD;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            sync_q  <= '0;
            line_q  <= 1'b0;
            cnt_q   <= '0;
            stall_q <= 1'b0;
            pulse_o <= '0;
        end else begin
            sync_q <= {sync_q[0], signal_i};
            line_q <= sync_q[1];

            if (edge_det) begin
                cnt_q   <= 8'd1;  // This cycle is the first of the new level
                stall_q <= 1'b0;
            end else begin
                if (cnt_q != 8'hff)
                    cnt_q <= cnt_q + 8'd1;
                if (stall_hit)
                    stall_q <= 1'b1;
            end

            pulse_o.valid <= edge_det || stall_hit;
            pulse_o.kind  <= edge_det ? kind : spdif_rx_pkg::PULSE_BAD;
        end
    end

endmodule

// ==== design/spdif_rate_hunter.sv ====
`timescale 1ns/1ps
`include "spdif_rx_defines.svh"

module spdif_rate_hunter (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       locked_i,
    output spdif_rx_pkg::rate_onehot_t rate_o,
    output spdif_rx_pkg::halfbit_len_t halfbit_len_o,
    output logic                       relock_o
);

    localparam int TIMER_W = $clog2(`SPDIF_UNLOCK_CYCLES + 1);

    logic               last_locked_q;
    logic [TIMER_W-1:0] unlock_cnt_q;
    logic               timeout;
    logic               step;

    assign timeout = (unlock_cnt_q == TIMER_W'(`SPDIF_UNLOCK_CYCLES));
    assign step    = timeout || (last_locked_q && !locked_i);  // Long hunt or lock lost

    always_ff @(posedge clk) begin
        if (rst) begin
            last_locked_q <= 1'b0;
            relock_o      <= 1'b0;
            unlock_cnt_q  <= '0;
            rate_o        <= spdif_rx_pkg::RATE_192;
        end else begin
            last_locked_q <= locked_i;
            relock_o      <= locked_i && !last_locked_q;

            if (locked_i || timeout)
                unlock_cnt_q <= '0;
            else
                unlock_cnt_q <= unlock_cnt_q + 1'b1;

            if (step)
                rate_o <= rate_o[0] ? spdif_rx_pkg::RATE_192 : (rate_o >> 1);  // Toward 32k
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            halfbit_len_o <= spdif_rx_pkg::halfbit_len_t'(`SPDIF_HB_192);
        end else begin
            case (rate_o)
                spdif_rx_pkg::RATE_32:  halfbit_len_o <= spdif_rx_pkg::halfbit_len_t'(`SPDIF_HB_32);
                spdif_rx_pkg::RATE_441: halfbit_len_o <= spdif_rx_pkg::halfbit_len_t'(`SPDIF_HB_441);
                spdif_rx_pkg::RATE_48:  halfbit_len_o <= spdif_rx_pkg::halfbit_len_t'(`SPDIF_HB_48);
                spdif_rx_pkg::RATE_96:  halfbit_len_o <= spdif_rx_pkg::halfbit_len_t'(`SPDIF_HB_96);
                default:                halfbit_len_o <= spdif_rx_pkg::halfbit_len_t'(`SPDIF_HB_192);
            endcase
        end
    end

endmodule

// ==== design/spdif_rx_defines.svh ====
`ifndef SPDIF_RX_DEFINES_SVH
`define SPDIF_RX_DEFINES_SVH

// Clocks without lock before the rate hunter tries the next rate
`define SPDIF_UNLOCK_CYCLES 16383

// Width of a half-bit length in clocks
`define SPDIF_HB_W 5

// Half-bit lengths in system clocks per candidate sample rate
`define SPDIF_HB_32  24
`define SPDIF_HB_441 17  // Nominal 17.4 rounded down
`define SPDIF_HB_48  16
`define SPDIF_HB_96  8
`define SPDIF_HB_192 4

`endif

// ==== design/spdif_rx_pkg.sv ====
`include "spdif_rx_defines.svh"

package spdif_rx_pkg;

    typedef logic [`SPDIF_HB_W-1:0] halfbit_len_t;
    typedef logic [7:0]             pulse_len_t;
    typedef logic [23:0]            audio_word_t;
    typedef logic [191:0]           status_block_t;  // Bit 0 is frame 0
    typedef logic [4:0]             rate_onehot_t;   // Bit 0 is 32 kHz

    localparam rate_onehot_t RATE_32  = 5'b00001;
    localparam rate_onehot_t RATE_441 = 5'b00010;
    localparam rate_onehot_t RATE_48  = 5'b00100;
    localparam rate_onehot_t RATE_96  = 5'b01000;
    localparam rate_onehot_t RATE_192 = 5'b10000;

    typedef enum logic [1:0] {PULSE_ONE, PULSE_TWO, PULSE_THREE, PULSE_BAD} pulse_kind_e;
    typedef enum logic [1:0] {PRE_NONE, PRE_B, PRE_M, PRE_W} preamble_e;
    typedef enum logic [1:0] {ST_HUNT, ST_PREAMBLE, ST_SLOTS} parser_state_e;

    typedef struct packed {
        logic        valid;
        pulse_kind_e kind;
    } pulse_t;

    typedef struct packed {
        audio_word_t audio;
        logic        validity;
        logic        user;
        logic        status;
        logic        left;         // B or M preamble
        logic        block_start;  // B preamble
    } subframe_t;

endpackage

// ==== design/spdif_rx_top.sv ====
`timescale 1ns/1ps

module spdif_rx_top (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        signal_i,
    output spdif_rx_pkg::audio_word_t   data_o,
    output logic                        ack_o,
    output logic                        lrck_o,
    output logic                        locked_o,
    output logic                        relock_o,
    output spdif_rx_pkg::status_block_t udata_o,
    output spdif_rx_pkg::status_block_t cdata_o,
    output spdif_rx_pkg::rate_onehot_t  rate_o
);

    spdif_rx_pkg::pulse_t       pulse;
    spdif_rx_pkg::subframe_t    subframe;
    spdif_rx_pkg::halfbit_len_t halfbit_len;

    assign data_o = subframe.audio;
    assign lrck_o = subframe.left;

    spdif_bmc_decoder decoder_i (
        .clk           (clk),
        .rst           (rst),
        .signal_i      (signal_i),
        .halfbit_len_i (halfbit_len),
        .pulse_o       (pulse)
    );

    spdif_subframe_parser parser_i (
        .clk        (clk),
        .rst        (rst),
        .pulse_i    (pulse),
        .subframe_o (subframe),
        .ack_o      (ack_o),
        .locked_o   (locked_o)
    );

    spdif_status_collector collector_i (
        .clk        (clk),
        .rst        (rst),
        .subframe_i (subframe),
        .ack_i      (ack_o),
        .cdata_o    (cdata_o),
        .udata_o    (udata_o)
    );

    spdif_rate_hunter hunter_i (
        .clk           (clk),
        .rst           (rst),
        .locked_i      (locked_o),
        .rate_o        (rate_o),
        .halfbit_len_o (halfbit_len),
        .relock_o      (relock_o)
    );

endmodule

// ==== design/spdif_status_collector.sv ====
`timescale 1ns/1ps

module spdif_status_collector (
    input  logic                        clk,
    input  logic                        rst,
    input  spdif_rx_pkg::subframe_t     subframe_i,
    input  logic                        ack_i,
    output spdif_rx_pkg::status_block_t cdata_o,
    output spdif_rx_pkg::status_block_t udata_o
);

    spdif_rx_pkg::status_block_t c_asm_q;
    spdif_rx_pkg::status_block_t u_asm_q;
    logic [7:0]                  frame_q;  // Next frame index in the block
    logic                        take;

    // Only the left subframe carries the collected C and U bits
    assign take = ack_i && subframe_i.left;

    always_ff @(posedge clk) begin
        if (rst) begin
            c_asm_q <= '0;
            u_asm_q <= '0;
            frame_q <= '0;
            cdata_o <= '0;
            udata_o <= '0;
        end else if (take) begin
            if (subframe_i.block_start) begin
                cdata_o <= c_asm_q;
                udata_o <= u_asm_q;
                c_asm_q <= {191'd0, subframe_i.status};  // Frame 0 of the new block
                u_asm_q <= {191'd0, subframe_i.user};
                frame_q <= 8'd1;
            end else if (frame_q < 8'd192) begin
                c_asm_q[frame_q] <= subframe_i.status;
                u_asm_q[frame_q] <= subframe_i.user;
                frame_q          <= frame_q + 8'd1;
            end
        end
    end

endmodule

// ==== design/spdif_subframe_parser.sv ====
`timescale 1ns/1ps

module spdif_subframe_parser (
    input  logic                    clk,
    input  logic                    rst,
    input  spdif_rx_pkg::pulse_t    pulse_i,
    output spdif_rx_pkg::subframe_t subframe_o,
    output logic                    ack_o,
    output logic                    locked_o
);

    spdif_rx_pkg::parser_state_e state_q;
    logic [1:0]                  pre_idx_q;   // Pulse index inside the preamble
    spdif_rx_pkg::pulse_kind_e   pre1_q;
    spdif_rx_pkg::pulse_kind_e   pre2_q;
    spdif_rx_pkg::preamble_e     pre_kind_q;
    spdif_rx_pkg::preamble_e     pre_dec;
    logic [6:0]                  hb_cnt_q;    // Half-bits since preamble start
    logic [6:0]                  hb_next;
    logic [1:0]                  pulse_hb;
    logic                        on_time_q;
    logic                        half_q;      // First half of a one seen
    logic [27:0]                 slots_q;
    logic [27:0]                 slots_next;
    logic                        slot_done;
    logic                        slot_bit;
    logic                        slot_err;
    logic                        last_slot;

    // Pulses after the leading three are B 1 1 3, M 3 1 1 or W 2 1 2
    function automatic spdif_rx_pkg::preamble_e decode_pre(
        input spdif_rx_pkg::pulse_kind_e p1,
        input spdif_rx_pkg::pulse_kind_e p2,
        input spdif_rx_pkg::pulse_kind_e p3
    );
        if (p1 == spdif_rx_pkg::PULSE_ONE && p2 == spdif_rx_pkg::PULSE_ONE &&
            p3 == spdif_rx_pkg::PULSE_THREE)
            return spdif_rx_pkg::PRE_B;
        if (p1 == spdif_rx_pkg::PULSE_THREE && p2 == spdif_rx_pkg::PULSE_ONE &&
            p3 == spdif_rx_pkg::PULSE_ONE)
            return spdif_rx_pkg::PRE_M;
        if (p1 == spdif_rx_pkg::PULSE_TWO && p2 == spdif_rx_pkg::PULSE_ONE &&
            p3 == spdif_rx_pkg::PULSE_TWO)
            return spdif_rx_pkg::PRE_W;
        return spdif_rx_pkg::PRE_NONE;
    endfunction

    assign pre_dec = decode_pre(pre1_q, pre2_q, pulse_i.kind);

    always_comb begin
        case (pulse_i.kind)
            spdif_rx_pkg::PULSE_ONE: pulse_hb = 2'd1;
            spdif_rx_pkg::PULSE_TWO: pulse_hb = 2'd2;
            default:                 pulse_hb = 2'd3;
        endcase
    end

    assign hb_next = hb_cnt_q + {5'd0, pulse_hb};

    // Two short pulses make a one and one long pulse makes a zero
    always_comb begin
        slot_done = 1'b0;
        slot_bit  = 1'b0;
        slot_err  = 1'b0;
        case (pulse_i.kind)
            spdif_rx_pkg::PULSE_ONE: begin
                slot_done = half_q;
                slot_bit  = 1'b1;
            end
            spdif_rx_pkg::PULSE_TWO: begin
                slot_done = !half_q;
                slot_err  = half_q;
            end
            default: slot_err = 1'b1;
        endcase
    end

    assign slots_next = {slot_bit, slots_q[27:1]};  // Slot 4 lands in bit 0
    assign last_slot  = slot_done && (hb_next == 7'd64);

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q    <= spdif_rx_pkg::ST_HUNT;
            pre_idx_q  <= '0;
            pre_kind_q <= spdif_rx_pkg::PRE_NONE;
            hb_cnt_q   <= '0;
            on_time_q  <= 1'b0;
            half_q     <= 1'b0;
            locked_o   <= 1'b0;
            ack_o      <= 1'b0;
            subframe_o <= '0;
        end else begin
            ack_o <= 1'b0;
            if (pulse_i.valid) begin
                hb_cnt_q <= hb_next;
                if (pulse_i.kind == spdif_rx_pkg::PULSE_BAD) begin
                    locked_o <= 1'b0;
                    state_q  <= spdif_rx_pkg::ST_HUNT;
                end else begin
                    case (state_q)
                        spdif_rx_pkg::ST_HUNT: begin
                            if (pulse_i.kind == spdif_rx_pkg::PULSE_THREE) begin
                                state_q   <= spdif_rx_pkg::ST_PREAMBLE;
                                pre_idx_q <= 2'd1;
                                hb_cnt_q  <= 7'd3;
                                on_time_q <= 1'b0;  // No earlier preamble to measure from
                            end
                        end
                        spdif_rx_pkg::ST_PREAMBLE: begin
                            pre_idx_q <= pre_idx_q + 2'd1;
                            case (pre_idx_q)
                                2'd0: begin
                                    if (pulse_i.kind == spdif_rx_pkg::PULSE_THREE) begin
                                        hb_cnt_q  <= 7'd3;
                                        on_time_q <= (hb_cnt_q == 7'd64);
                                    end else begin
                                        locked_o <= 1'b0;  // Boundary passed without a preamble
                                        state_q  <= spdif_rx_pkg::ST_HUNT;
                                    end
                                end
                                2'd1: pre1_q <= pulse_i.kind;
                                2'd2: pre2_q <= pulse_i.kind;
                                default: begin
                                    if (pre_dec == spdif_rx_pkg::PRE_NONE) begin
                                        locked_o <= 1'b0;
                                        state_q  <= spdif_rx_pkg::ST_HUNT;
                                    end else begin
                                        pre_kind_q <= pre_dec;
                                        half_q     <= 1'b0;
                                        state_q    <= spdif_rx_pkg::ST_SLOTS;
                                        if (on_time_q)
                                            locked_o <= 1'b1;
                                    end
                                end
                            endcase
                        end
                        default: begin
                            if (slot_err) begin
                                locked_o <= 1'b0;
                                state_q  <= spdif_rx_pkg::ST_HUNT;
                            end else begin
                                half_q <= (pulse_i.kind == spdif_rx_pkg::PULSE_ONE) && !half_q;
                                if (slot_done)
                                    slots_q <= slots_next;
                                if (last_slot) begin
                                    state_q   <= spdif_rx_pkg::ST_PREAMBLE;
                                    pre_idx_q <= 2'd0;
                                    ack_o     <= locked_o && !(^slots_next);  // Even parity
                                    subframe_o.audio       <= slots_next[23:0];
                                    subframe_o.validity    <= slots_next[24];
                                    subframe_o.user        <= slots_next[25];
                                    subframe_o.status      <= slots_next[26];
                                    subframe_o.left        <=
                                        (pre_kind_q != spdif_rx_pkg::PRE_W);
                                    subframe_o.block_start <=
                                        (pre_kind_q == spdif_rx_pkg::PRE_B);
                                end
                            end
                        end
                    endcase
                end
            end
        end
    end

endmodule

// ==== spdif_rx.f ====
+incdir+design
design/spdif_rx_pkg.sv
design/spdif_bmc_decoder.sv
design/spdif_subframe_parser.sv
design/spdif_status_collector.sv
design/spdif_rate_hunter.sv
design/spdif_rx_top.sv
tb/spdif_rx_assert.sv
tb/spdif_rx_tb.sv

// ==== tb/spdif_rx_assert.sv ====
`timescale 1ns/1ps

module spdif_rx_assert (
    input logic                       clk,
    input logic                       rst,
    input logic                       ack_i,
    input logic                       locked_i,
    input logic                       relock_i,
    input spdif_rx_pkg::rate_onehot_t rate_i
);

    int onehot_fails = 0;
    int relock_fails = 0;
    int ack_fails    = 0;

    rate_onehot: assert property (@(posedge clk) disable iff (rst) $onehot(rate_i))
        else begin
            onehot_fails++;
            $error("rate_o is not one-hot: %b", rate_i);
        end

    relock_single: assert property (@(posedge clk) disable iff (rst) relock_i |=> !relock_i)
        else begin
            relock_fails++;
            $error("relock_o stayed high for two cycles");
        end

    // Audio words are acknowledged only while locked
    ack_when_locked: assert property (@(posedge clk) disable iff (rst) ack_i |-> locked_i)
        else begin
            ack_fails++;
            $error("ack_o high while locked_o is low");
        end

endmodule

bind spdif_rx_top spdif_rx_assert assert_i (
    .clk      (clk),
    .rst      (rst),
    .ack_i    (ack_o),
    .locked_i (locked_o),
    .relock_i (relock_o),
    .rate_i   (rate_o)
);

// ==== tb/spdif_rx_tb.sv ====
`timescale 1ns/1ps
`include "spdif_rx_defines.svh"

module spdif_rx_tb;

    localparam int HB           = `SPDIF_HB_48;  // Stream runs at 48 kHz
    localparam int FRAME_CYCLES = 128 * HB;
    localparam int CYCLE_LIMIT  = 2 * `SPDIF_UNLOCK_CYCLES + 2 * 192 * FRAME_CYCLES + 20000;

    typedef struct packed {
        logic                      left;
        logic                      bad;
        spdif_rx_pkg::audio_word_t audio;
    } sent_t;

    logic                        clk;
    logic                        rst;
    logic                        signal_i;
    spdif_rx_pkg::audio_word_t   data_o;
    logic                        ack_o;
    logic                        lrck_o;
    logic                        locked_o;
    logic                        relock_o;
    spdif_rx_pkg::status_block_t udata_o;
    spdif_rx_pkg::status_block_t cdata_o;
    spdif_rx_pkg::rate_onehot_t  rate_o;

    sent_t                       sent_q[$];
    sent_t                       head;
    spdif_rx_pkg::rate_onehot_t  rate_log[$];
    spdif_rx_pkg::rate_onehot_t  last_rate = spdif_rx_pkg::RATE_192;
    int                          seed = 78;
    int                          frame_pos = 0;  // Frame index inside the 192-frame block
    int                          value_errs = 0;
    int                          other_errs = 0;
    int                          ack_cnt = 0;
    int                          drop_cnt = 0;
    int                          relock_cnt = 0;
    int                          cycle_cnt = 0;
    string                       cur_test = "reset";

    spdif_rx_top dut_i (
        .clk      (clk),
        .rst      (rst),
        .signal_i (signal_i),
        .data_o   (data_o),
        .ack_o    (ack_o),
        .lrck_o   (lrck_o),
        .locked_o (locked_o),
        .relock_o (relock_o),
        .udata_o  (udata_o),
        .cdata_o  (cdata_o),
        .rate_o   (rate_o)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

    always @(negedge clk) begin
        if (!rst) begin
            if (relock_o) begin
                relock_cnt++;
                sent_q.delete();  // Words sent before lock never get an ack
            end
            if (rate_o !== last_rate) begin
                rate_log.push_back(rate_o);
                last_rate = rate_o;
            end
            if (ack_o) begin
                ack_cnt++;
                while (sent_q.size() > 0 && sent_q[0].bad) begin
                    head = sent_q.pop_front();
                    drop_cnt++;
                end
                if (sent_q.size() == 0) begin
                    other_errs++;
                    $display("ERROR %s: ack_o rose with no audio word waiting", cur_test);
                end else begin
                    head = sent_q.pop_front();
                    check_word(cur_test, head.audio, data_o);
                    check_bit({cur_test, " lrck"}, head.left, lrck_o);
                end
            end
        end
    end

    task automatic check_word(string name, spdif_rx_pkg::audio_word_t exp,
                              spdif_rx_pkg::audio_word_t act);
        if (act !== exp) begin
            value_errs++;
            $display("FAIL %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_block(string name, spdif_rx_pkg::status_block_t exp,
                               spdif_rx_pkg::status_block_t act);
        if (act !== exp) begin
            value_errs++;
            $display("FAIL %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_rate(string name, spdif_rx_pkg::rate_onehot_t exp,
                              spdif_rx_pkg::rate_onehot_t act);
        if (act !== exp) begin
            value_errs++;
            $display("FAIL %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic check_bit(string name, logic exp, logic act);
        if (act !== exp) begin
            value_errs++;
            $display("FAIL %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    function automatic spdif_rx_pkg::audio_word_t random_sample();
        return spdif_rx_pkg::audio_word_t'($random(seed));
    endfunction

    task automatic send_pulse(int halves);
        signal_i = ~signal_i;  // Every pulse starts with a transition
        repeat (halves * HB) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic send_subframe(spdif_rx_pkg::preamble_e pre, spdif_rx_pkg::audio_word_t audio,
                                 logic c, logic u, logic bad_par);
        logic [27:0] slots;
        int          pre_pulses[4];
        int          i;
        slots     = {1'b0, c, u, 1'b0, audio};  // Parity, C, U, V, audio LSB first
        slots[27] = (^slots[26:0]) ^ bad_par;
        case (pre)
            spdif_rx_pkg::PRE_B: pre_pulses = '{3, 1, 1, 3};
            spdif_rx_pkg::PRE_M: pre_pulses = '{3, 3, 1, 1};
            default:             pre_pulses = '{3, 2, 1, 2};
        endcase
        foreach (pre_pulses[k])
            send_pulse(pre_pulses[k]);
        for (i = 0; i < 28; i++) begin
            if (slots[i]) begin
                send_pulse(1);
                send_pulse(1);
            end else begin
                send_pulse(2);
            end
        end
        sent_q.push_back('{left: (pre != spdif_rx_pkg::PRE_W), bad: bad_par, audio: audio});
    endtask

    // Right subframe carries inverted C and U so stray collection shows up
    task automatic send_frame(logic [1:0] bad, spdif_rx_pkg::audio_word_t left_word,
                              spdif_rx_pkg::audio_word_t right_word, logic c, logic u);
        send_subframe(frame_pos == 0 ? spdif_rx_pkg::PRE_B : spdif_rx_pkg::PRE_M,
                      left_word, c, u, bad[0]);
        send_subframe(spdif_rx_pkg::PRE_W, right_word, ~c, ~u, bad[1]);
        frame_pos = (frame_pos + 1) % 192;
    endtask

    task automatic send_random_frames(int n, int bad_at);
        int i;
        for (i = 0; i < n; i++)
            send_frame({i == bad_at, 1'b0}, random_sample(), random_sample(), 1'b0, 1'b0);
    endtask

    task automatic verify_reset_state;
        cur_test = "reset_state";
        check_bit("reset_state ack", 1'b0, ack_o);
        check_bit("reset_state locked", 1'b0, locked_o);
        check_bit("reset_state relock", 1'b0, relock_o);
        check_rate(cur_test, spdif_rx_pkg::RATE_192, rate_o);
        check_block("reset_state cdata", '0, cdata_o);
        check_block("reset_state udata", '0, udata_o);
    endtask

    task automatic hunt_rate;
        spdif_rx_pkg::rate_onehot_t exp_steps[2];
        int                         n;
        cur_test  = "rate_hunting";
        exp_steps = '{spdif_rx_pkg::RATE_96, spdif_rx_pkg::RATE_48};  // Down from 192 kHz
        n         = 0;
        while (relock_cnt == 0 && n < 40) begin
            send_random_frames(1, -1);
            n++;
        end
        if (relock_cnt == 0) begin
            other_errs++;
            $display("ERROR rate_hunting: receiver never locked on the 48 kHz stream");
        end
        send_random_frames(2, -1);
        check_bit("rate_hunting locked", 1'b1, locked_o);
        check_rate(cur_test, spdif_rx_pkg::RATE_48, rate_o);
        if (relock_cnt != 1) begin
            other_errs++;
            $display("ERROR rate_hunting: relock_o pulsed %0d times instead of once", relock_cnt);
        end
        if (rate_log.size() != 2) begin
            other_errs++;
            $display("ERROR rate_hunting: rate_o changed %0d times instead of twice",
                     rate_log.size());
        end else begin
            foreach (rate_log[i])
                check_rate("rate_hunting step", exp_steps[i], rate_log[i]);
        end
    endtask

    task automatic stream_audio_words;
        int acks_before;
        cur_test    = "audio_words";
        acks_before = ack_cnt;
        send_random_frames(8, -1);
        if (ack_cnt - acks_before != 16) begin
            other_errs++;
            $display("ERROR audio_words: %0d acks seen for 16 subframes", ack_cnt - acks_before);
        end
    endtask

    task automatic corrupt_parity;
        int acks_before;
        int drops_before;
        cur_test     = "parity_error";
        acks_before  = ack_cnt;
        drops_before = drop_cnt;
        send_random_frames(4, 1);  // Right subframe of frame 1 has bad parity
        if (ack_cnt - acks_before != 7 || drop_cnt - drops_before != 1) begin
            other_errs++;
            $display("ERROR parity_error: %0d acks and %0d dropped words, expected 7 and 1",
                     ack_cnt - acks_before, drop_cnt - drops_before);
        end
        check_bit("parity_error locked", 1'b1, locked_o);
        if (relock_cnt != 1) begin
            other_errs++;
            $display("ERROR parity_error: lock was lost and regained after a parity error");
        end
    endtask

    task automatic collect_status_blocks;
        spdif_rx_pkg::status_block_t cpat;
        spdif_rx_pkg::status_block_t upat;
        int                          i;
        cur_test = "status_blocks";
        for (i = 0; i < 6; i++) begin
            cpat[i*32 +: 32] = $random(seed);
            upat[i*32 +: 32] = $random(seed);
        end
        frame_pos = 0;
        for (i = 0; i < 192; i++)
            send_frame(2'b00, random_sample(), random_sample(), cpat[i], upat[i]);
        send_frame(2'b00, random_sample(), random_sample(), 1'b0, 1'b0);  // Next B publishes
        check_block("status_blocks cdata", cpat, cdata_o);
        check_block("status_blocks udata", upat, udata_o);
    endtask

    task automatic drop_signal;
        int n;
        cur_test = "signal_loss";
        n        = 0;
        while (locked_o && n < 8 * HB) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (locked_o) begin
            other_errs++;
            $display("ERROR signal_loss: locked_o stayed high on a silent line");
        end
        @(posedge clk);
        #1;
        check_rate(cur_test, spdif_rx_pkg::RATE_441, rate_o);
    endtask

    task automatic report_and_finish;
        int assert_errs;
        assert_errs = dut_i.assert_i.onehot_fails + dut_i.assert_i.relock_fails +
                      dut_i.assert_i.ack_fails;
        $display("Errors: %0d value mismatches, %0d other failures, %0d assertion failures",
                 value_errs, other_errs, assert_errs);
        if (value_errs + other_errs + assert_errs == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    endtask

    initial begin
        wait (cycle_cnt >= CYCLE_LIMIT);
        other_errs++;
        $display("ERROR timeout: run reached %0d cycles before the tests ended", CYCLE_LIMIT);
        report_and_finish();
    end

    initial begin
        rst      = 1'b1;
        signal_i = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        verify_reset_state();
        hunt_rate();
        stream_audio_words();
        corrupt_parity();
        collect_status_blocks();
        drop_signal();
        report_and_finish();
    end

endmodule
